// File: vertex_job_control.f
hdl/vertex_job_pkg.sv
hdl/vertex_fetch_fsm.sv
hdl/vertex_chunk_counter.sv
hdl/vertex_line_store.sv
hdl/vertex_job_builder.sv
hdl/vertex_job_fifo.sv
hdl/vertex_job_control.sv
test/vertex_job_control_asserts.sv
test/vertex_job_control_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the vertex job fetcher testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
	--top-module vertex_job_control_tb -f vertex_job_control.f \
	-o vertex_job_control_sim > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/vertex_job_control_sim > sim.log 2>&1
grep -qx "ALL CHECKS PASSED" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

// File: test/vertex_job_control_tb.sv
////////////////////////////////////////////////////////////
// Testbench with memory model, consumer and directed tests
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vertex_job_control_tb;
	import vertex_job_pkg::*;

	localparam int MAX_CYCLES = 4000;
	localparam int MAX_CHUNKS = 8;

	typedef struct packed {
		logic [ADDR_BITS-1:0] addr;
		array_kind_t kind;
		logic [CHUNK_BITS-1:0] size;
		int chunk;
		int kept_before;
	} cmd_t;

	logic clock = 1'b0;
	logic rstn;
	logic start;
	logic [ADDR_BITS-1:0] in_degree_base;
	logic [ADDR_BITS-1:0] out_degree_base;
	logic [ADDR_BITS-1:0] edges_idx_base;
	logic [31:0] num_vertices;
	logic data_valid = 1'b0;
	array_kind_t data_kind = IN_DEGREE;
	logic [LINE_BITS-1:0] data_line = '0;
	logic vertex_request = 1'b0;
	logic cmd_valid;
	logic [ADDR_BITS-1:0] cmd_addr;
	array_kind_t cmd_kind;
	logic [CHUNK_BITS-1:0] cmd_size;
	logic busy;
	logic vertex_valid;
	logic [VERTEX_BITS-1:0] vertex_id;
	logic [VERTEX_BITS-1:0] vertex_in_degree;
	logic [VERTEX_BITS-1:0] vertex_out_degree;
	logic [VERTEX_BITS-1:0] vertex_edges_idx;
	logic [31:0] filtered_count;
	logic [31:0] edge_job_count;

	// Memory image and expectations
	logic [31:0] rng_state = 32'he1e1_9be7;
	logic [LINE_BITS-1:0] line_mem [3][MAX_CHUNKS];
	logic [4*VERTEX_BITS-1:0] exp_vertices [$];
	cmd_t exp_cmds [$];
	cmd_t pending [$];
	logic [31:0] exp_filtered = '0;
	logic [31:0] exp_edges = '0;
	int kept_total = 0;
	int popped_total = 0;
	int resp_wait = 0;
	int quiet_cycles = 0;
	int cycle_count = 0;
	bit pop_enable = 1'b1;

	vertex_job_control dut (
		.clock(clock), .rstn(rstn), .start(start),
		.in_degree_base(in_degree_base), .out_degree_base(out_degree_base),
		.edges_idx_base(edges_idx_base), .num_vertices(num_vertices),
		.data_valid(data_valid), .data_kind(data_kind), .data_line(data_line),
		.vertex_request(vertex_request), .cmd_valid(cmd_valid), .cmd_addr(cmd_addr),
		.cmd_kind(cmd_kind), .cmd_size(cmd_size), .busy(busy),
		.vertex_valid(vertex_valid), .vertex_id(vertex_id),
		.vertex_in_degree(vertex_in_degree), .vertex_out_degree(vertex_out_degree),
		.vertex_edges_idx(vertex_edges_idx), .filtered_count(filtered_count),
		.edge_job_count(edge_job_count)
	);

	always #10 clock = ~clock;

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Error: run did not finish within %0d cycles", MAX_CYCLES);
			abort_run();
		end
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("CHECKS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else begin
			$display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic require(input bit cond, input string what);
		assert (cond)
		else begin
			$display("Error: %s", what);
			abort_run();
		end
	endtask

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Memory holds each word big endian
	function automatic logic [31:0] swap_bytes(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	task automatic prepare_job(input int n, input logic [31:0] in_base,
		input logic [31:0] out_base, input logic [31:0] edges_base, input bit allow_zero);
		cmd_t cmd;
		logic [31:0] r;
		logic [VERTEX_BITS-1:0] in_val;
		logic [VERTEX_BITS-1:0] out_val;
		logic [VERTEX_BITS-1:0] edges_val;
		int size;
		for (int c = 0; c * LINE_VERTS < n; c++) begin
			size = (n - c * LINE_VERTS < LINE_VERTS) ? n - c * LINE_VERTS : LINE_VERTS;
			for (int kind = 0; kind < 3; kind++) begin
				cmd.kind = array_kind_t'(kind);
				cmd.addr = (kind == 0 ? in_base : kind == 1 ? out_base : edges_base) +
					32'(c * LINE_BYTES);
				cmd.size = CHUNK_BITS'(size);
				cmd.chunk = c;
				cmd.kept_before = kept_total;
				exp_cmds.push_back(cmd);
			end
			for (int k = 0; k < LINE_VERTS; k++) begin
				r = next_random();
				in_val = next_random();
				edges_val = next_random();
				// Small out-degrees, about a quarter zero when allowed
				out_val = {24'h0, r[7:0]};
				if (allow_zero && (r[9:8] == 2'b00 || (c == 0 && k == 1)))
					out_val = '0;
				else if (out_val == '0)
					out_val = 32'h1;
				line_mem[0][c][k*VERTEX_BITS +: VERTEX_BITS] = swap_bytes(in_val);
				line_mem[1][c][k*VERTEX_BITS +: VERTEX_BITS] = swap_bytes(out_val);
				line_mem[2][c][k*VERTEX_BITS +: VERTEX_BITS] = swap_bytes(edges_val);
				if (k < size && out_val == '0) begin
					exp_filtered++;
				end else if (k < size) begin
					exp_vertices.push_back({32'(c * LINE_VERTS + k), in_val, out_val, edges_val});
					exp_edges += out_val;
					kept_total++;
				end
			end
		end
	endtask

	task automatic launch_job(input int n, input logic [31:0] in_base,
		input logic [31:0] out_base, input logic [31:0] edges_base);
		@(negedge clock);
		in_degree_base = in_base;
		out_degree_base = out_base;
		edges_idx_base = edges_base;
		num_vertices = 32'(n);
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
	endtask

	task automatic await_idle();
		do begin
			@(negedge clock);
		end while (busy || exp_vertices.size() != 0);
		require(exp_cmds.size() == 0 && pending.size() == 0,
			"job ended with commands or lines still outstanding");
		compare_value("filtered_count", filtered_count, exp_filtered);
		compare_value("edge_job_count", edge_job_count, exp_edges);
	endtask

	////////////////////////////////////////////////////////////
	// Memory model and consumer
	////////////////////////////////////////////////////////////

	task automatic accept_commands();
		cmd_t exp;
		if (!cmd_valid) begin
			quiet_cycles++;
		end else begin
			require(exp_cmds.size() > 0, "read command issued when none was expected");
			exp = exp_cmds.pop_front();
			// The out-degree and edge index commands follow with no gap
			require(exp.kind == IN_DEGREE || quiet_cycles == 0,
				"read commands of one chunk not on consecutive cycles");
			quiet_cycles = 0;
			compare_value("cmd_kind", 32'(cmd_kind), 32'(exp.kind));
			compare_value("cmd_addr", cmd_addr, exp.addr);
			compare_value("cmd_size", 32'(cmd_size), 32'(exp.size));
			require(exp.kept_before - popped_total <= LINE_VERTS,
				"command issued with fewer than four free job FIFO entries");
			if (pending.size() == 0)
				resp_wait = 3 + int'(next_random() % 3);
			pending.push_back(exp);
		end
	endtask

	// Lines go back in random kind order
	task automatic return_lines();
		int pick;
		cmd_t resp;
		data_valid = 1'b0;
		if (pending.size() > 0 && resp_wait > 0) begin
			resp_wait--;
		end else if (pending.size() > 0) begin
			pick = int'(next_random() % 32'(pending.size()));
			resp = pending[pick];
			pending.delete(pick);
			data_valid = 1'b1;
			data_kind = resp.kind;
			data_line = line_mem[int'(resp.kind)][resp.chunk];
			resp_wait = int'(next_random() % 2);
		end
	endtask

	task automatic pop_vertices();
		logic [4*VERTEX_BITS-1:0] exp;
		vertex_request = 1'b0;
		if (pop_enable && vertex_valid) begin
			require(exp_vertices.size() > 0, "vertex_valid high with no vertex expected");
			exp = exp_vertices.pop_front();
			compare_value("vertex_id", vertex_id, exp[127:96]);
			compare_value("vertex_in_degree", vertex_in_degree, exp[95:64]);
			compare_value("vertex_out_degree", vertex_out_degree, exp[63:32]);
			compare_value("vertex_edges_idx", vertex_edges_idx, exp[31:0]);
			popped_total++;
			vertex_request = 1'b1;
		end
	endtask

	always @(negedge clock) begin
		if (rstn) begin
			accept_commands();
			return_lines();
			pop_vertices();
		end
	end

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic idle_after_reset();
		compare_value("busy", 32'(busy), 32'h0);
		compare_value("cmd_valid", 32'(cmd_valid), 32'h0);
		compare_value("vertex_valid", 32'(vertex_valid), 32'h0);
		compare_value("filtered_count", filtered_count, 32'h0);
		compare_value("edge_job_count", edge_job_count, 32'h0);
	endtask

	// Chunks of 4, 4 and 2 with some zero out-degrees
	task automatic ten_vertex_job();
		pop_enable = 1'b1;
		prepare_job(10, 32'h1000_0000, 32'h2000_0000, 32'h3000_0040, 1'b1);
		launch_job(10, 32'h1000_0000, 32'h2000_0000, 32'h3000_0040);
		await_idle();
	endtask

	// Consumer holds off until the fetch stalls on a full FIFO
	task automatic stalled_consumer();
		pop_enable = 1'b0;
		prepare_job(20, 32'h0400_0100, 32'h0500_0200, 32'h0600_0300, 1'b0);
		launch_job(20, 32'h0400_0100, 32'h0500_0200, 32'h0600_0300);
		do begin
			@(negedge clock);
		end while (!(vertex_valid && quiet_cycles >= 40));
		require(busy && exp_cmds.size() == 9,
			"fetch did not stall after two chunks with the consumer held off");
		pop_enable = 1'b1;
		await_idle();
	endtask

	task automatic restart_with_new_bases();
		pop_enable = 1'b1;
		prepare_job(7, 32'h7700_0000, 32'h8800_0010, 32'h9900_0020, 1'b1);
		launch_job(7, 32'h7700_0000, 32'h8800_0010, 32'h9900_0020);
		await_idle();
	endtask

	initial begin
		rstn = 1'b0;
		start = 1'b0;
		in_degree_base = '0;
		out_degree_base = '0;
		edges_idx_base = '0;
		num_vertices = '0;
		repeat (4) @(negedge clock);
		rstn = 1'b1;
		idle_after_reset();
		ten_vertex_job();
		stalled_consumer();
		restart_with_new_bases();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/vertex_job_control_asserts.sv
////////////////////////////////////////////////////////////
// Bound checks on command issue and job FIFO pushes
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vertex_job_control_asserts (
	input logic clock,
	input logic rstn,
	input vertex_job_pkg::fetch_state_t state,
	input logic cmd_valid,
	input logic room_for_line,
	input logic push,
	input logic pop,
	input logic not_empty,
	input logic [vertex_job_pkg::FIFO_PTR_BITS:0] count
);
	import vertex_job_pkg::*;

	// A full FIFO only takes a push paired with a real pop
	push_not_full: assert property (@(posedge clock) disable iff (!rstn)
		push |-> (32'(count) < 32'(JOB_FIFO_DEPTH)) || (pop && not_empty))
		else $error("job FIFO pushed while full");

	// Command states run in order, one cycle each, out of FETCH_WAIT_ROOM
	cmd_in_cmd_state: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> (state == FETCH_CMD_IN && $past(state) == FETCH_WAIT_ROOM) ||
			(state == FETCH_CMD_OUT && $past(state) == FETCH_CMD_IN) ||
			(state == FETCH_CMD_EDGES && $past(state) == FETCH_CMD_OUT))
		else $error("cmd_valid high outside an ordered command burst");

	cmd_needs_room: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> room_for_line)
		else $error("command issued without room for a line");

endmodule

// Each instance only sees its own module, the other inputs stay idle
bind vertex_fetch_fsm vertex_job_control_asserts fsm_checks (
	.clock(clock), .rstn(rstn), .state(state), .cmd_valid(cmd_valid),
	.room_for_line(room_for_line), .push(1'b0), .pop(1'b0),
	.not_empty(1'b0), .count('0)
);

bind vertex_job_fifo vertex_job_control_asserts fifo_checks (
	.clock(clock), .rstn(rstn), .state(vertex_job_pkg::FETCH_IDLE),
	.cmd_valid(1'b0), .room_for_line(1'b1), .push(push), .pop(pop),
	.not_empty(not_empty), .count(count)
);

`default_nettype wire

// File: hdl/vertex_job_control.sv
////////////////////////////////////////////////////////////
// Vertex job fetcher top level
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vertex_job_control (
	input  logic clock,
	input  logic rstn,
	input  logic start,
	input  logic [vertex_job_pkg::ADDR_BITS-1:0] in_degree_base,
	input  logic [vertex_job_pkg::ADDR_BITS-1:0] out_degree_base,
	input  logic [vertex_job_pkg::ADDR_BITS-1:0] edges_idx_base,
	input  logic [31:0] num_vertices,
	input  logic data_valid,
	input  vertex_job_pkg::array_kind_t data_kind,
	input  logic [vertex_job_pkg::LINE_BITS-1:0] data_line,
	input  logic vertex_request,
	output logic cmd_valid,
	output logic [vertex_job_pkg::ADDR_BITS-1:0] cmd_addr,
	output vertex_job_pkg::array_kind_t cmd_kind,
	output logic [vertex_job_pkg::CHUNK_BITS-1:0] cmd_size,
	output logic busy,
	output logic vertex_valid,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0] vertex_id,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0] vertex_in_degree,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0] vertex_out_degree,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0] vertex_edges_idx,
	output logic [31:0] filtered_count,
	output logic [31:0] edge_job_count
);
	import vertex_job_pkg::*;

	logic load, take_chunk, shift_step, shift_clear;
	logic clear_ready, shift_valid;
	logic has_more, shift_last, all_ready, room_for_line;
	logic [CHUNK_BITS-1:0] shift_index;
	logic [ADDR_BITS-1:0] line_offset;
	logic [VERTEX_BITS-1:0] in_word, out_word, edges_word;
	logic push;
	logic [VERTEX_BITS-1:0] job_id, job_in, job_out, job_edges;

	assign cmd_addr = ((cmd_kind == IN_DEGREE) ? in_degree_base :
		(cmd_kind == OUT_DEGREE) ? out_degree_base : edges_idx_base) + line_offset;

	vertex_fetch_fsm u_fsm (
		.clock(clock), .rstn(rstn), .start(start),
		.has_more(has_more), .shift_last(shift_last),
		.all_ready(all_ready), .room_for_line(room_for_line),
		.load(load), .take_chunk(take_chunk),
		.shift_step(shift_step), .shift_clear(shift_clear),
		.clear_ready(clear_ready), .shift_valid(shift_valid),
		.busy(busy), .cmd_valid(cmd_valid), .cmd_kind(cmd_kind)
	);

	vertex_chunk_counter u_counter (
		.clock(clock), .rstn(rstn), .load(load), .take_chunk(take_chunk),
		.shift_step(shift_step), .shift_clear(shift_clear),
		.num_vertices(num_vertices), .chunk_size(cmd_size),
		.shift_index(shift_index), .line_offset(line_offset),
		.has_more(has_more), .shift_last(shift_last)
	);

	vertex_line_store u_lines (
		.clock(clock), .rstn(rstn), .data_valid(data_valid),
		.clear_ready(clear_ready), .data_kind(data_kind),
		.data_line(data_line), .shift_index(shift_index),
		.all_ready(all_ready), .in_word(in_word),
		.out_word(out_word), .edges_word(edges_word)
	);

	vertex_job_builder u_builder (
		.clock(clock), .rstn(rstn), .load(load), .shift_valid(shift_valid),
		.in_word(in_word), .out_word(out_word), .edges_word(edges_word),
		.push(push), .job_id(job_id), .job_in(job_in),
		.job_out(job_out), .job_edges(job_edges),
		.filtered_count(filtered_count), .edge_job_count(edge_job_count)
	);

	vertex_job_fifo u_fifo (
		.clock(clock), .rstn(rstn), .push(push), .pop(vertex_request),
		.in_id(job_id), .in_in(job_in), .in_out(job_out), .in_edges(job_edges),
		.not_empty(vertex_valid), .room_for_line(room_for_line),
		.head_id(vertex_id), .head_in(vertex_in_degree),
		.head_out(vertex_out_degree), .head_edges(vertex_edges_idx)
	);

endmodule

`default_nettype wire

// File: hdl/vertex_job_fifo.sv
////////////////////////////////////////////////////////////
// Show-ahead job FIFO with room-for-a-line flag
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vertex_job_fifo (
	input  logic clock,
	input  logic rstn,
	input  logic push,
	input  logic pop,
	input  logic [vertex_job_pkg::VERTEX_BITS-1:0] in_id,
	input  logic [vertex_job_pkg::VERTEX_BITS-1:0] in_in,
	input  logic [vertex_job_pkg::VERTEX_BITS-1:0] in_out,
	input  logic [vertex_job_pkg::VERTEX_BITS-1:0] in_edges,
	output logic not_empty,
	output logic room_for_line,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0] head_id,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0] head_in,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0] head_out,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0] head_edges
);
	import vertex_job_pkg::*;

	logic [4*VERTEX_BITS-1:0] mem [JOB_FIFO_DEPTH];
	logic [FIFO_PTR_BITS-1:0] wr_ptr;
	logic [FIFO_PTR_BITS-1:0] rd_ptr;
	logic [FIFO_PTR_BITS:0] count;
	logic do_pop;

	assign not_empty = (count != '0);
	assign do_pop = pop && not_empty;

	// A push still in flight counts as occupied
	assign room_for_line = (32'(count) + 32'(push)) <= 32'(JOB_FIFO_DEPTH - LINE_VERTS);

	assign {head_id, head_in, head_out, head_edges} = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (push)
			mem[wr_ptr] <= {in_id, in_in, in_out, in_edges};
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + FIFO_PTR_BITS'(1);
			if (do_pop)
				rd_ptr <= rd_ptr + FIFO_PTR_BITS'(1);
			if (push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hdl/vertex_job_builder.sv
////////////////////////////////////////////////////////////
// Vertex assembly, id numbering, zero out-degree filter
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vertex_job_builder (
	input  logic clock,
	input  logic rstn,
	input  logic load,
	input  logic shift_valid,
	input  logic [vertex_job_pkg::VERTEX_BITS-1:0] in_word,
	input  logic [vertex_job_pkg::VERTEX_BITS-1:0] out_word,
	input  logic [vertex_job_pkg::VERTEX_BITS-1:0] edges_word,
	output logic push,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0] job_id,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0] job_in,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0] job_out,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0] job_edges,
	output logic [31:0] filtered_count,
	output logic [31:0] edge_job_count
);
	import vertex_job_pkg::*;

	logic [VERTEX_BITS-1:0] next_id;
	logic keep;

	// Vertices without outgoing edges produce no work
	assign keep = (out_word != '0);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			push <= 1'b0;
			next_id <= '0;
			filtered_count <= '0;
			edge_job_count <= '0;
		end else begin
			push <= shift_valid && keep;
			if (load)
				next_id <= '0;
			else if (shift_valid)
				next_id <= next_id + VERTEX_BITS'(1);

			if (shift_valid && keep)
				edge_job_count <= edge_job_count + 32'(out_word);
			else if (shift_valid)
				filtered_count <= filtered_count + 32'd1;
		end
	end

	always_ff @(posedge clock) begin
		if (shift_valid) begin
			job_id <= next_id;
			job_in <= in_word;
			job_out <= out_word;
			job_edges <= edges_word;
		end
	end

endmodule

`default_nettype wire

// File: hdl/vertex_line_store.sv
////////////////////////////////////////////////////////////
// Line registers per array kind, ready flags
// Word select at the shift index with byte swap
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vertex_line_store (
	input  logic clock,
	input  logic rstn,
	input  logic data_valid,
	input  logic clear_ready,
	input  vertex_job_pkg::array_kind_t data_kind,
	input  logic [vertex_job_pkg::LINE_BITS-1:0] data_line,
	input  logic [vertex_job_pkg::CHUNK_BITS-1:0] shift_index,
	output logic all_ready,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0] in_word,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0] out_word,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0] edges_word
);
	import vertex_job_pkg::*;

	logic [LINE_BITS-1:0] in_line;
	logic [LINE_BITS-1:0] out_line;
	logic [LINE_BITS-1:0] edges_line;
	logic [2:0] ready;
	logic [LINE_SEL_BITS-1:0] sel;

	// Memory words arrive big endian
	function automatic logic [VERTEX_BITS-1:0] pick_word(
		input logic [LINE_BITS-1:0] line,
		input logic [LINE_SEL_BITS-1:0] idx
	);
		logic [VERTEX_BITS-1:0] word;
		word = line[idx*VERTEX_BITS +: VERTEX_BITS];
		return {<<8{word}};
	endfunction

	always_ff @(posedge clock) begin
		if (data_valid) begin
			case (data_kind)
				IN_DEGREE: in_line <= data_line;
				OUT_DEGREE: out_line <= data_line;
				default: edges_line <= data_line;
			endcase
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			ready <= '0;
		end else begin
			if (clear_ready)
				ready <= '0;
			if (data_valid)
				ready[data_kind] <= 1'b1;
		end
	end

	assign all_ready = &ready;

	assign sel = shift_index[LINE_SEL_BITS-1:0];
	assign in_word = pick_word(in_line, sel);
	assign out_word = pick_word(out_line, sel);
	assign edges_word = pick_word(edges_line, sel);

endmodule

`default_nettype wire

// File: hdl/vertex_chunk_counter.sv
////////////////////////////////////////////////////////////
// Remaining vertices, line offset and shift index
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vertex_chunk_counter (
	input  logic clock,
	input  logic rstn,
	input  logic load,
	input  logic take_chunk,
	input  logic shift_step,
	input  logic shift_clear,
	input  logic [31:0] num_vertices,
	output logic [vertex_job_pkg::CHUNK_BITS-1:0] chunk_size,
	output logic [vertex_job_pkg::CHUNK_BITS-1:0] shift_index,
	output logic [vertex_job_pkg::ADDR_BITS-1:0] line_offset,
	output logic has_more,
	output logic shift_last
);
	import vertex_job_pkg::*;

	logic [31:0] remaining;
	logic [ADDR_BITS-1:0] next_offset;
	logic [CHUNK_BITS-1:0] next_size;

	// Full line unless the tail of the job is shorter
	assign next_size = (remaining > LINE_VERTS) ? CHUNK_BITS'(LINE_VERTS) :
		remaining[CHUNK_BITS-1:0];

	assign has_more = (remaining != '0);
	assign shift_last = (shift_index == chunk_size - CHUNK_BITS'(1));

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			remaining <= '0;
			next_offset <= '0;
			line_offset <= '0;
			chunk_size <= '0;
			shift_index <= '0;
		end else begin
			if (load) begin
				remaining <= num_vertices;
				next_offset <= '0;
				line_offset <= '0;
			end else if (take_chunk) begin
				// line_offset holds still while the three commands go out
				chunk_size <= next_size;
				remaining <= remaining - 32'(next_size);
				line_offset <= next_offset;
				next_offset <= next_offset + ADDR_BITS'(LINE_BYTES);
			end

			if (shift_clear)
				shift_index <= '0;
			else if (shift_step)
				shift_index <= shift_index + CHUNK_BITS'(1);
		end
	end

endmodule

`default_nettype wire

// File: hdl/vertex_fetch_fsm.sv
////////////////////////////////////////////////////////////
// Fetch FSM for command issue, data wait and shift-out
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vertex_fetch_fsm (
	input  logic clock,
	input  logic rstn,
	input  logic start,
	input  logic has_more,
	input  logic shift_last,
	input  logic all_ready,
	input  logic room_for_line,
	output logic load,
	output logic take_chunk,
	output logic shift_step,
	output logic shift_clear,
	output logic clear_ready,
	output logic shift_valid,
	output logic busy,
	output logic cmd_valid,
	output vertex_job_pkg::array_kind_t cmd_kind
);
	import vertex_job_pkg::*;

	fetch_state_t state;
	fetch_state_t next_state;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= FETCH_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			FETCH_IDLE: if (start) next_state = FETCH_LOAD;
			FETCH_LOAD: next_state = FETCH_WAIT_ROOM;
			FETCH_WAIT_ROOM: begin
				if (!has_more)
					next_state = FETCH_IDLE;
				else if (room_for_line)
					next_state = FETCH_CMD_IN;
			end
			FETCH_CMD_IN: next_state = FETCH_CMD_OUT;
			FETCH_CMD_OUT: next_state = FETCH_CMD_EDGES;
			FETCH_CMD_EDGES: next_state = FETCH_WAIT_DATA;
			FETCH_WAIT_DATA: if (all_ready) next_state = FETCH_SHIFT;
			FETCH_SHIFT: begin
				// Last vertex of the chunk decides between next chunk and idle
				if (shift_last)
					next_state = has_more ? FETCH_WAIT_ROOM : FETCH_IDLE;
			end
			default: next_state = FETCH_IDLE;
		endcase
	end

	assign busy = (state != FETCH_IDLE);
	assign load = (state == FETCH_LOAD);
	assign take_chunk = (state == FETCH_WAIT_ROOM) && has_more && room_for_line;

	// Lines complete, release the flags and rewind the shift index
	assign clear_ready = (state == FETCH_WAIT_DATA) && all_ready;
	assign shift_clear = clear_ready;

	assign shift_valid = (state == FETCH_SHIFT);
	assign shift_step = shift_valid;

	assign cmd_valid = (state == FETCH_CMD_IN) || (state == FETCH_CMD_OUT) ||
		(state == FETCH_CMD_EDGES);

	always_comb begin
		case (state)
			FETCH_CMD_OUT: cmd_kind = OUT_DEGREE;
			FETCH_CMD_EDGES: cmd_kind = EDGES_IDX;
			default: cmd_kind = IN_DEGREE;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/vertex_job_pkg.sv
////////////////////////////////////////////////////////////
// Widths, sizes and enums for the vertex job fetcher
////////////////////////////////////////////////////////////

`default_nettype none

package vertex_job_pkg;

	// Vertex and cacheline geometry
	localparam int VERTEX_BITS = 32;
	localparam int LINE_VERTS = 4;
	localparam int LINE_BITS = VERTEX_BITS * LINE_VERTS;
	localparam int LINE_BYTES = LINE_BITS / 8;
	localparam int LINE_SEL_BITS = $clog2(LINE_VERTS);

	localparam int ADDR_BITS = 32;
	localparam int CHUNK_BITS = 3;

	// Job FIFO sizing
	localparam int JOB_FIFO_DEPTH = 8;
	localparam int FIFO_PTR_BITS = $clog2(JOB_FIFO_DEPTH);

	typedef enum logic [1:0] {
		IN_DEGREE,
		OUT_DEGREE,
		EDGES_IDX
	} array_kind_t;

	typedef enum logic [2:0] {
		FETCH_IDLE,
		FETCH_LOAD,
		FETCH_WAIT_ROOM,
		FETCH_CMD_IN,
		FETCH_CMD_OUT,
		FETCH_CMD_EDGES,
		FETCH_WAIT_DATA,
		FETCH_SHIFT
	} fetch_state_t;

endpackage

`default_nettype wire
